// File: hdl/capture_core.sv
// capture core that decodes sump commands, samples channels around a trigger and reads them back
`timescale 1ns/1ps

module capture_core (
  input  logic                                     clk_i,
  input  logic                                     reset_i,
  input  logic [logic_analyzer_pkg::CHLS-1:0]      chls_i,
  input  logic_analyzer_pkg::sump_cmd_u            cmd_i,
  input  logic                                     cmd_stb_i,
  output logic [logic_analyzer_pkg::CHLS-1:0]      tx_data_o,
  output logic                                     tx_valid_o,
  input  logic                                     tx_ready_i,
  output logic                                     mem_we_o,
  output logic [logic_analyzer_pkg::ADDR_BITS-1:0] mem_addr_o,
  output logic [logic_analyzer_pkg::CHLS-1:0]      mem_wdata_o,
  input  logic [logic_analyzer_pkg::CHLS-1:0]      mem_rdata_i
);
  import logic_analyzer_pkg::*;

  logic [2:0]           state_q;
  logic [CHLS-1:0]      mask_q;
  logic [CHLS-1:0]      value_q;
  logic [ADDR_BITS:0]   read_cnt_q;
  logic [ADDR_BITS:0]   delay_cnt_q;
  logic [ADDR_BITS:0]   remain_q;   // samples still to write, counted from the trigger
  logic [ADDR_BITS:0]   left_q;     // words still owed to the transmitter
  logic [ADDR_BITS-1:0] addr_q;
  logic                 trig_hit;
  logic                 capturing;

  // only the masked channels take part in the comparison
  assign trig_hit  = ((chls_i ^ value_q) & mask_q) == '0;
  assign capturing = (state_q == ST_ARMED) || (state_q == ST_POST);

  assign mem_we_o    = capturing;  // one sample per clock while capturing
  assign mem_addr_o  = addr_q;
  assign mem_wdata_o = chls_i;

  // the ram port holds the word for the current address as long as addr_q stands still
  assign tx_data_o = (state_q == ST_ID) ? ID_WORD : mem_rdata_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q     <= ST_IDLE;
      tx_valid_o  <= 1'b0;
      mask_q      <= '0;
      value_q     <= '0;
      read_cnt_q  <= MAX_COUNT;
      delay_cnt_q <= MAX_COUNT;
      remain_q    <= '0;
      left_q      <= '0;
      addr_q      <= '0;
    end else begin
      case (state_q)
        ST_ARMED, ST_POST: begin
          if (state_q == ST_POST || trig_hit) begin
            if (remain_q == 1) begin
              // addr_q stays on the newest sample, readout walks down from here
              state_q <= ST_READ;
              left_q  <= read_cnt_q;
            end else begin
              state_q  <= ST_POST;
              remain_q <= remain_q - 1'b1;
              addr_q   <= addr_q + 1'b1;
            end
          end else begin
            addr_q <= addr_q + 1'b1;  // circular history before the trigger
          end
        end
        ST_READ: begin
          if (!tx_valid_o) begin
            tx_valid_o <= 1'b1;  // the ram had one cycle for the current address
          end else if (tx_ready_i) begin
            tx_valid_o <= 1'b0;
            addr_q     <= addr_q - 1'b1;
            left_q     <= left_q - 1'b1;
            if (left_q == 1) state_q <= ST_IDLE;
          end
        end
        ST_ID: begin
          if (tx_ready_i) begin
            tx_valid_o <= 1'b0;
            state_q    <= ST_IDLE;
          end
        end
        default: ;
      endcase

      // commands are decoded last so that a reset overrides any state above
      if (cmd_stb_i) begin
        case (cmd_i.f.opcode)
          OP_RESET: begin
            state_q    <= ST_IDLE;
            tx_valid_o <= 1'b0;
          end
          OP_RUN: begin
            if (state_q == ST_IDLE) begin
              state_q  <= ST_ARMED;
              remain_q <= delay_cnt_q;
            end
          end
          OP_ID: begin
            if (state_q == ST_IDLE) begin
              state_q    <= ST_ID;
              tx_valid_o <= 1'b1;
            end
          end
          OP_SET_COUNT: begin
            read_cnt_q  <= cmd_i.f.arg[ADDR_BITS:0];
            delay_cnt_q <= cmd_i.f.arg[DELAY_LSB+ADDR_BITS:DELAY_LSB];
          end
          OP_TRIG_MASK:  mask_q  <= cmd_i.f.arg;
          OP_TRIG_VALUE: value_q <= cmd_i.f.arg;
          default: ;  // unsupported opcodes are ignored
        endcase
      end
    end
  end

endmodule

// File: hdl/logic_analyzer.sv
// top level of the logic analyzer that wires receiver, capture core, sample memory and transmitter
`timescale 1ns/1ps

module logic_analyzer (
  input  logic                                clk_i,
  input  logic                                reset_i,
  input  logic [logic_analyzer_pkg::CHLS-1:0] chls_i,
  input  logic                                rx_i,
  output logic                                tx_o
);
  import logic_analyzer_pkg::*;

  sump_cmd_u            cmd;
  logic                 cmd_stb;
  logic [CHLS-1:0]      tx_data;
  logic                 tx_valid;
  logic                 tx_ready;
  logic                 mem_we;
  logic [ADDR_BITS-1:0] mem_addr;
  logic [CHLS-1:0]      mem_wdata;
  logic [CHLS-1:0]      mem_rdata;

  uart_rx urx0 (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .rx_i      (rx_i),
    .cmd_o     (cmd),
    .cmd_stb_o (cmd_stb)
  );

  capture_core core0 (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .chls_i      (chls_i),
    .cmd_i       (cmd),
    .cmd_stb_i   (cmd_stb),
    .tx_data_o   (tx_data),
    .tx_valid_o  (tx_valid),
    .tx_ready_i  (tx_ready),
    .mem_we_o    (mem_we),
    .mem_addr_o  (mem_addr),
    .mem_wdata_o (mem_wdata),
    .mem_rdata_i (mem_rdata)
  );

  sample_ram ram0 (
    .clk_i   (clk_i),
    .we_i    (mem_we),
    .addr_i  (mem_addr),
    .wdata_i (mem_wdata),
    .rdata_o (mem_rdata)
  );

  uart_tx utx0 (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .data_i  (tx_data),
    .valid_i (tx_valid),
    .ready_o (tx_ready),
    .tx_o    (tx_o)
  );

endmodule

// File: hdl/logic_analyzer_pkg.sv
// shared sizes, opcodes, state codes and command layout of the sump logic analyzer
package logic_analyzer_pkg;

  localparam int CHLS        = 32;  // sampled channels, exactly one word
  localparam int ADDR_BITS   = 5;   // 32 samples of history
  localparam int CLK_PER_BIT = 10;
  localparam int BYTE_BITS   = 8;
  localparam int CMD_BYTES   = 5;   // opcode plus a 32-bit argument
  localparam int DELAY_LSB   = 16;  // delay count sits in the upper half of the argument

  // bit timing shared by both uart directions
  localparam int CNT_BITS = $clog2(CLK_PER_BIT);
  localparam logic [CNT_BITS-1:0] BIT_LAST  = CNT_BITS'(CLK_PER_BIT - 1);
  localparam logic [CNT_BITS-1:0] HALF_LAST = CNT_BITS'(CLK_PER_BIT / 2 - 1);

  // read and delay counts come out of reset at the full memory depth
  localparam logic [ADDR_BITS:0] MAX_COUNT = {1'b1, {ADDR_BITS{1'b0}}};

  localparam logic [BYTE_BITS-1:0] OP_RESET      = 8'h00;
  localparam logic [BYTE_BITS-1:0] OP_RUN        = 8'h01;
  localparam logic [BYTE_BITS-1:0] OP_ID         = 8'h02;
  localparam logic [BYTE_BITS-1:0] OP_SET_COUNT  = 8'h81;
  localparam logic [BYTE_BITS-1:0] OP_TRIG_MASK  = 8'hC0;
  localparam logic [BYTE_BITS-1:0] OP_TRIG_VALUE = 8'hC1;

  // low byte goes out first, so the host reads "1ALS"
  localparam logic [CHLS-1:0] ID_WORD = "SLA1";

  // uart receiver states
  localparam logic [1:0] RX_IDLE  = 2'd0;
  localparam logic [1:0] RX_START = 2'd1;
  localparam logic [1:0] RX_DATA  = 2'd2;
  localparam logic [1:0] RX_STOP  = 2'd3;

  // uart transmitter states
  localparam logic [1:0] TX_IDLE  = 2'd0;
  localparam logic [1:0] TX_START = 2'd1;
  localparam logic [1:0] TX_DATA  = 2'd2;
  localparam logic [1:0] TX_STOP  = 2'd3;

  // capture core states
  localparam logic [2:0] ST_IDLE  = 3'd0;
  localparam logic [2:0] ST_ARMED = 3'd1;
  localparam logic [2:0] ST_POST  = 3'd2;
  localparam logic [2:0] ST_READ  = 3'd3;
  localparam logic [2:0] ST_ID    = 3'd4;

  // one received command, filled bytewise and decoded fieldwise
  typedef union packed {
    logic [CMD_BYTES-1:0][BYTE_BITS-1:0] bytes;  // arrival order, opcode in byte 0
    struct packed {
      logic [(CMD_BYTES-1)*BYTE_BITS-1:0] arg;   // little endian on the wire
      logic [BYTE_BITS-1:0]               opcode;
    } f;
  } sump_cmd_u;

endpackage

// File: hdl/sample_ram.sv
// single-port sample memory with a registered read port
`timescale 1ns/1ps

module sample_ram (
  input  logic                                     clk_i,
  input  logic                                     we_i,
  input  logic [logic_analyzer_pkg::ADDR_BITS-1:0] addr_i,
  input  logic [logic_analyzer_pkg::CHLS-1:0]      wdata_i,
  output logic [logic_analyzer_pkg::CHLS-1:0]      rdata_o
);
  import logic_analyzer_pkg::*;

  logic [CHLS-1:0] mem [2**ADDR_BITS];

  // read returns the old contents when the same address is written
  always_ff @(posedge clk_i) begin
    if (we_i) mem[addr_i] <= wdata_i;
    rdata_o <= mem[addr_i];
  end

endmodule

// File: hdl/uart_rx.sv
// uart receiver that assembles host bytes into one-byte or five-byte sump commands
`timescale 1ns/1ps

module uart_rx (
  input  logic                          clk_i,
  input  logic                          reset_i,
  input  logic                          rx_i,
  output logic_analyzer_pkg::sump_cmd_u cmd_o,
  output logic                          cmd_stb_o
);
  import logic_analyzer_pkg::*;

  logic                 rx_meta;
  logic                 rx_sync;
  logic                 rx_prev;
  logic [1:0]           state_q;
  logic [CNT_BITS-1:0]  clk_cnt_q;
  logic [2:0]           bit_cnt_q;
  logic [2:0]           byte_cnt_q;
  logic [BYTE_BITS-1:0] shift_q;
  logic                 bit_end;
  logic                 byte_ok;

  assign bit_end = (clk_cnt_q == BIT_LAST);
  assign byte_ok = (state_q == RX_STOP) && bit_end && rx_sync;  // stop bit seen high

  // two flops against metastability and a third one for the falling edge
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_meta <= rx_i;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q    <= RX_IDLE;
      clk_cnt_q  <= '0;
      bit_cnt_q  <= '0;
      byte_cnt_q <= '0;
      cmd_stb_o  <= 1'b0;
    end else begin
      cmd_stb_o <= 1'b0;
      clk_cnt_q <= bit_end ? '0 : clk_cnt_q + 1'b1;
      case (state_q)
        RX_IDLE: begin
          clk_cnt_q <= '0;
          if (!rx_sync && rx_prev) state_q <= RX_START;
        end
        RX_START: begin
          // half a bit in, the start bit must still be low or it was a glitch
          if (clk_cnt_q == HALF_LAST) begin
            clk_cnt_q <= '0;
            bit_cnt_q <= '0;
            state_q   <= rx_sync ? RX_IDLE : RX_DATA;
          end
        end
        RX_DATA: begin
          if (bit_end) begin
            bit_cnt_q <= bit_cnt_q + 1'b1;
            if (bit_cnt_q == 3'd7) state_q <= RX_STOP;
          end
        end
        default: begin
          if (bit_end) begin
            state_q <= RX_IDLE;
            if (!rx_sync) begin
              byte_cnt_q <= '0;  // framing error drops whatever was collected
            end else if ((byte_cnt_q == '0 && !shift_q[BYTE_BITS-1]) ||
                         byte_cnt_q == 3'(CMD_BYTES - 1)) begin
              byte_cnt_q <= '0;
              cmd_stb_o  <= 1'b1;
            end else begin
              byte_cnt_q <= byte_cnt_q + 1'b1;
            end
          end
        end
      endcase
    end
  end

  // data bits arrive lsb first and are shifted in from the top
  always_ff @(posedge clk_i) begin
    if (state_q == RX_DATA && bit_end) shift_q <= {rx_sync, shift_q[BYTE_BITS-1:1]};
    if (byte_ok) cmd_o.bytes[byte_cnt_q] <= shift_q;
  end

endmodule

// File: hdl/uart_tx.sv
// uart transmitter that takes 32-bit words by handshake and sends them as four bytes
`timescale 1ns/1ps

module uart_tx (
  input  logic                                clk_i,
  input  logic                                reset_i,
  input  logic [logic_analyzer_pkg::CHLS-1:0] data_i,
  input  logic                                valid_i,
  output logic                                ready_o,
  output logic                                tx_o
);
  import logic_analyzer_pkg::*;

  logic [1:0]          state_q;
  logic [CNT_BITS-1:0] clk_cnt_q;
  logic [2:0]          bit_cnt_q;
  logic [1:0]          byte_cnt_q;
  logic [CHLS-1:0]     word_q;
  logic                bit_end;

  assign ready_o = (state_q == TX_IDLE);
  assign bit_end = (clk_cnt_q == BIT_LAST);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q    <= TX_IDLE;
      tx_o       <= 1'b1;  // line idles high
      clk_cnt_q  <= '0;
      bit_cnt_q  <= '0;
      byte_cnt_q <= '0;
    end else begin
      clk_cnt_q <= bit_end ? '0 : clk_cnt_q + 1'b1;
      case (state_q)
        TX_IDLE: begin
          clk_cnt_q <= '0;
          if (valid_i) begin
            state_q    <= TX_START;
            tx_o       <= 1'b0;
            byte_cnt_q <= '0;
          end
        end
        TX_START: begin
          if (bit_end) begin
            state_q   <= TX_DATA;
            tx_o      <= word_q[0];
            bit_cnt_q <= '0;
          end
        end
        TX_DATA: begin
          if (bit_end) begin
            bit_cnt_q <= bit_cnt_q + 1'b1;
            if (bit_cnt_q == 3'd7) begin
              state_q <= TX_STOP;
              tx_o    <= 1'b1;
            end else begin
              tx_o <= word_q[1];  // word_q shifts on this same edge
            end
          end
        end
        default: begin
          if (bit_end) begin
            if (byte_cnt_q == 2'd3) begin
              state_q <= TX_IDLE;  // ready again right after the last stop bit
            end else begin
              byte_cnt_q <= byte_cnt_q + 1'b1;
              state_q    <= TX_START;
              tx_o       <= 1'b0;
            end
          end
        end
      endcase
    end
  end

  // one right shift per data bit, so byte 0 leaves first and each byte lsb first
  always_ff @(posedge clk_i) begin
    if (valid_i && ready_o) begin
      word_q <= data_i;
    end else if (state_q == TX_DATA && bit_end) begin
      word_q <= word_q >> 1;
    end
  end

endmodule

// File: logic_analyzer.f
hdl/logic_analyzer_pkg.sv
hdl/uart_rx.sv
hdl/capture_core.sv
hdl/sample_ram.sv
hdl/uart_tx.sv
hdl/logic_analyzer.sv
sim/logic_analyzer_checker.sv
sim/logic_analyzer_tb.sv

// File: run_sim.sh
#!/bin/sh
# builds the testbench with verilator, runs it and looks for the pass line in the log
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f logic_analyzer.f --top-module logic_analyzer_tb
./obj_dir/Vlogic_analyzer_tb | tee sim.log
if grep -q "^Simulation PASSED$" sim.log; then
  exit 0
else
  exit 1
fi

// File: sim/logic_analyzer_checker.sv
// protocol assertions on the handshake, memory write, serial line and command strobe
`timescale 1ns/1ps

module logic_analyzer_checker (
  input logic                                clk_i,
  input logic                                reset_i,
  input logic                                cmd_stb_i,
  input logic [logic_analyzer_pkg::CHLS-1:0] tx_data_i,
  input logic                                tx_valid_i,
  input logic                                tx_ready_i,
  input logic                                mem_we_i,
  input logic                                tx_i
);
  logic handshake_seen;  // set by the first word the transmitter accepts
  int   failures = 0;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      handshake_seen <= 1'b0;
    end else if (tx_valid_i && tx_ready_i) begin
      handshake_seen <= 1'b1;
    end
  end

  valid_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    tx_valid_i && !tx_ready_i |=> tx_valid_i && $stable(tx_data_i))
    else begin
      $error("tx word dropped or changed while waiting for ready");
      failures++;
    end

  // capture only starts right after a command, and never overlaps a reply
  we_start: assert property (@(posedge clk_i) disable iff (reset_i)
    $rose(mem_we_i) |-> $past(cmd_stb_i))
    else begin
      $error("sample write started without a command");
      failures++;
    end
  we_excl: assert property (@(posedge clk_i) disable iff (reset_i) !(mem_we_i && tx_valid_i))
    else begin
      $error("sample write while a word is offered to the transmitter");
      failures++;
    end

  line_idle: assert property (@(posedge clk_i) disable iff (reset_i) !handshake_seen |-> tx_i)
    else begin
      $error("serial line left idle before any word was sent");
      failures++;
    end

  stb_single: assert property (@(posedge clk_i) disable iff (reset_i) cmd_stb_i |=> !cmd_stb_i)
    else begin
      $error("command strobe high for two cycles");
      failures++;
    end

endmodule

bind logic_analyzer logic_analyzer_checker chk0 (
  .clk_i      (clk_i),
  .reset_i    (reset_i),
  .cmd_stb_i  (cmd_stb),
  .tx_data_i  (tx_data),
  .tx_valid_i (tx_valid),
  .tx_ready_i (tx_ready),
  .mem_we_i   (mem_we),
  .tx_i       (tx_o)
);

// File: sim/logic_analyzer_tb.sv
// testbench for the logic analyzer with a host uart model, a channel counter and five tests
`timescale 1ns/1ps

module logic_analyzer_tb;
  import logic_analyzer_pkg::*;

  localparam int BYTE_NS     = 10 * CLK_PER_BIT * 40;
  localparam int TEST_BYTES  = 5 + 75 + 48 + 21;  // bytes sent plus bytes expected over all tests
  localparam int WATCHDOG_NS = 2 * TEST_BYTES * BYTE_NS;

  logic            clk;
  logic            reset;
  logic [CHLS-1:0] chls;
  logic            rx;
  logic            tx;
  logic [7:0]      rx_bytes[$];  // bytes decoded from the serial output
  int              errors = 0;
  int              tests_run = 0;
  int              tests_failed = 0;

  logic_analyzer dut0 (
    .clk_i   (clk),
    .reset_i (reset),
    .chls_i  (chls),
    .rx_i    (rx),
    .tx_o    (tx)
  );

  always #20 clk = ~clk;

  always @(posedge clk) chls <= chls + 32'd1;  // channels count up by one per clock

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected) else begin
      $display("** Error: %s expected %h, got %h", name, expected, actual);
      errors++;
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    assert (cond) else begin
      $display("%s", what);
      errors++;
    end
  endtask

  // host receiver that samples every bit of the line in its middle
  always begin : host_rx
    logic [7:0] b;
    @(negedge tx);
    repeat (CLK_PER_BIT / 2) @(posedge clk);
    for (int i = 0; i < 8; i++) begin
      repeat (CLK_PER_BIT) @(posedge clk);
      b[i] = tx;
    end
    repeat (CLK_PER_BIT) @(posedge clk);
    check_true(tx, "host receiver saw a low stop bit");
    rx_bytes.push_back(b);
  end

  task automatic send_byte(input logic [7:0] data);
    logic [9:0] frame;
    frame = {1'b1, data, 1'b0};  // start bit leaves first
    for (int i = 0; i < 10; i++) begin
      rx <= frame[i];
      repeat (CLK_PER_BIT) @(posedge clk);
    end
  endtask

  task automatic send_cmd(input logic [7:0] opcode, input logic [31:0] arg);
    send_byte(opcode);
    if (opcode[7]) begin
      for (int i = 0; i < 4; i++) send_byte(arg[8*i +: 8]);
    end
  endtask

  task automatic take_word(output logic [31:0] word);
    while (rx_bytes.size() < 4) @(posedge clk);
    for (int i = 0; i < 4; i++) word[8*i +: 8] = rx_bytes.pop_front();
  endtask

  task automatic finish_test(input string name, input int errors_before);
    tests_run++;
    if (errors != errors_before) tests_failed++;
    $display("test %s: %0d errors", name, errors - errors_before);
  endtask

  initial begin
    logic [31:0] word;
    logic [31:0] prev;
    logic [31:0] words [8];
    int          mark;
    clk   = 1'b0;
    reset <= 1'b1;
    rx    <= 1'b1;
    void'($urandom(75));
    chls <= $urandom;
    repeat (8) @(posedge clk);
    reset <= 1'b0;

    mark = errors;
    repeat (200) begin
      @(posedge clk);
      check_value("tx_o", 32'h1, {31'b0, tx});
    end
    check_true(rx_bytes.size() == 0, "a byte was decoded on an idle line");
    finish_test("idle line", mark);

    mark = errors;
    send_byte(OP_ID);
    take_word(word);
    check_value("id word", {"S", "L", "A", "1"}, word);  // '1' is the low byte and arrives first
    finish_test("id", mark);

    mark = errors;
    send_cmd(OP_TRIG_MASK, 32'h0);
    send_cmd(OP_SET_COUNT, {16'd16, 16'd16});  // delay in the upper half and read count below
    send_cmd(OP_RUN, 32'h0);
    take_word(prev);
    for (int i = 1; i < 16; i++) begin
      take_word(word);
      check_value("readout word", prev - 32'd1, word);  // newest first from a counter
      prev = word;
    end
    finish_test("immediate capture", mark);

    mark = errors;
    send_cmd(OP_TRIG_MASK, 32'h0000_00FF);
    send_cmd(OP_TRIG_VALUE, 32'h0000_005A);
    send_cmd(OP_SET_COUNT, {16'd4, 16'd8});
    // 0x5a has just gone by, so the history is full long before the next match
    while (chls[7:0] != 8'h5B) @(posedge clk);
    send_cmd(OP_RUN, 32'h0);
    for (int i = 0; i < 8; i++) take_word(words[i]);
    check_value("trigger word low byte", 32'h5A, {24'h0, words[3][7:0]});
    for (int i = 1; i < 8; i++) check_value("readout word", words[i-1] - 32'd1, words[i]);
    finish_test("masked trigger", mark);

    mark = errors;
    send_cmd(OP_TRIG_MASK, 32'hFFFF_FFFF);
    send_cmd(OP_TRIG_VALUE, chls - 32'd1);  // the counter needs 2^32 clocks to get back there
    send_cmd(OP_RUN, 32'h0);
    repeat (5) send_byte(OP_RESET);
    repeat (40 * CLK_PER_BIT) @(posedge clk);
    check_true(rx_bytes.size() == 0, "a data word arrived after the abort");
    send_byte(OP_ID);
    take_word(word);
    check_value("id word after abort", {"S", "L", "A", "1"}, word);
    finish_test("abort", mark);

    $display("%0d tests, %0d failed, %0d errors, %0d assertion failures",
             tests_run, tests_failed, errors, dut0.chk0.failures);
    if (errors == 0 && dut0.chk0.failures == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("timeout, the tests did not finish within %0d ns", WATCHDOG_NS);
    $display("Simulation FAILED");
    $finish;
  end

endmodule
